// ==== include/eth_tx_consts.svh ====
`ifndef ETH_TX_CONSTS_SVH
`define ETH_TX_CONSTS_SVH

// ring geometry
`define SLOT_COUNT      4
`define SLOT_BYTES      64

// line framing
`define PREAMBLE_BYTES  7
`define GAP_CYCLES      12
`define PREAMBLE_BYTE   8'h55
`define SFD_BYTE        8'hd5

`define CRC_POLY        32'hedb8_8320   // reflected 802.3 polynomial
`define CRC_INIT        32'hffff_ffff

`endif

// ==== hw/eth_frame_pkg.sv ====
`default_nettype none

package eth_frame_pkg;

    typedef logic [7:0] byte_t;

    typedef logic [31:0] crc_t;   // reflected bit order

    // framer phases in line order
    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_sfd,
        st_payload,
        st_fcs,
        st_gap
    } tx_state_t;

endpackage

`default_nettype wire

// ==== hw/tx_buffer_pkg.sv ====
`default_nettype none

`include "eth_tx_consts.svh"

package tx_buffer_pkg;

    typedef logic [$clog2(`SLOT_COUNT)-1:0] slot_t;

    // one bit wider than an offset so a full slot length fits
    typedef logic [$clog2(`SLOT_BYTES + 1)-1:0] addr_t;

    typedef enum logic [1:0] {
        op_write      = 2'd0,
        op_write_len  = 2'd1,
        op_write_next = 2'd2
    } host_op_t;

endpackage

`default_nettype wire

// ==== hw/eth_tx_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// oldest committed slot, as seen by the framer
interface frame_fetch_if ();
    logic                 pending;
    tx_buffer_pkg::addr_t frame_len;
    tx_buffer_pkg::addr_t fetch_addr;
    eth_frame_pkg::byte_t fetch_byte;
    logic                 release_slot;   // one pulse per sent frame

    modport ring (
        output pending, frame_len, fetch_byte,
        input  fetch_addr, release_slot
    );

    modport framer (
        input  pending, frame_len, fetch_byte,
        output fetch_addr, release_slot
    );
endinterface

interface fcs_if ();
    logic                 crc_init;
    logic                 crc_update;
    eth_frame_pkg::byte_t crc_byte;
    eth_frame_pkg::crc_t  crc_value;   // already complemented

    modport framer (output crc_init, crc_update, crc_byte, input crc_value);

    modport crc (input crc_init, crc_update, crc_byte, output crc_value);
endinterface

`default_nettype wire

// ==== hw/packet_ring.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_consts.svh"

module packet_ring (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    start,
    input  tx_buffer_pkg::host_op_t operation,
    input  tx_buffer_pkg::addr_t    address,
    input  eth_frame_pkg::byte_t    value,
    output logic                    done,
    output tx_buffer_pkg::addr_t    result,
    frame_fetch_if.ring             fetch
);
    localparam int OFFSET_BITS = $clog2(`SLOT_BYTES);
    localparam int COUNT_BITS = $clog2(`SLOT_COUNT + 1);

    eth_frame_pkg::byte_t  mem [`SLOT_COUNT][`SLOT_BYTES];
    tx_buffer_pkg::addr_t  slot_len [`SLOT_COUNT];   // committed lengths
    tx_buffer_pkg::addr_t  open_len;
    tx_buffer_pkg::slot_t  wr_ptr;
    tx_buffer_pkg::slot_t  send_ptr;
    logic [COUNT_BITS-1:0] committed;
    logic                  in_range;
    logic                  full;
    logic                  do_write;
    logic                  do_commit;

    assign in_range = address < tx_buffer_pkg::addr_t'(`SLOT_BYTES);
    assign full = committed == COUNT_BITS'(`SLOT_COUNT);
    // when full the open slot aliases the oldest frame, so its bytes are kept
    assign do_write = start && operation == tx_buffer_pkg::op_write && in_range && !full;
    assign do_commit = start && operation == tx_buffer_pkg::op_write_next && !full;

    always_ff @(posedge clock) begin
        if (reset) begin
            done      <= 1'b0;
            wr_ptr    <= '0;
            send_ptr  <= '0;
            committed <= '0;
            open_len  <= '0;
        end else begin
            done <= start;
            if (do_commit) begin
                wr_ptr   <= wr_ptr + 1'b1;
                open_len <= '0;
            end else if (do_write && address >= open_len) begin
                open_len <= address + 1'b1;   // highest address plus one
            end
            if (fetch.release_slot) begin
                send_ptr <= send_ptr + 1'b1;
            end
            committed <= committed + COUNT_BITS'(do_commit) - COUNT_BITS'(fetch.release_slot);
        end
    end

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr][address[OFFSET_BITS-1:0]] <= value;
        end
        if (do_commit) begin
            slot_len[wr_ptr] <= open_len;
        end
        if (start) begin
            case (operation)
                tx_buffer_pkg::op_write:      result <= in_range ? '0 : 'd1;
                tx_buffer_pkg::op_write_len:  result <= open_len;
                tx_buffer_pkg::op_write_next: result <= full ? 'd1 : '0;
                default:                      result <= '0;
            endcase
        end
    end

    assign fetch.pending = committed != '0;
    assign fetch.frame_len = slot_len[send_ptr];
    assign fetch.fetch_byte = mem[send_ptr][fetch.fetch_addr[OFFSET_BITS-1:0]];

endmodule

`default_nettype wire

// ==== hw/fcs_crc32.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_consts.svh"

module fcs_crc32 (
    input  logic clock,
    input  logic reset,
    fcs_if.crc   crc
);
    eth_frame_pkg::crc_t crc_q;
    eth_frame_pkg::crc_t crc_next;

    // lsb first, one shift per data bit
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ crc.crc_byte[i]) begin
                crc_next = (crc_next >> 1) ^ `CRC_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            crc_q <= `CRC_INIT;
        end else if (crc.crc_init) begin
            crc_q <= `CRC_INIT;
        end else if (crc.crc_update) begin
            crc_q <= crc_next;
        end
    end

    assign crc.crc_value = ~crc_q;   // low byte leads on the wire

endmodule

`default_nettype wire

// ==== hw/frame_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_timer (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 load,
    input  tx_buffer_pkg::addr_t load_value,
    output logic                 expired
);
    tx_buffer_pkg::addr_t count;

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // a load of n gives a phase of n + 1 cycles
    assign expired = count == '0;

endmodule

`default_nettype wire

// ==== hw/tx_framer_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_consts.svh"

module tx_framer_fsm (
    input  logic                 clock,
    input  logic                 reset,
    frame_fetch_if.framer        fetch,
    fcs_if.framer                fcs,
    output logic                 timer_load,
    output tx_buffer_pkg::addr_t timer_value,
    input  logic                 timer_expired,
    output eth_frame_pkg::byte_t tx_data,
    output logic                 tx_en
);
    localparam int FCS_BYTES = 4;

    eth_frame_pkg::tx_state_t state;
    eth_frame_pkg::tx_state_t state_next;
    tx_buffer_pkg::addr_t     byte_addr;
    logic [1:0]               fcs_index;

    always_comb begin
        state_next = state;
        timer_load = 1'b0;
        timer_value = '0;
        case (state)
            eth_frame_pkg::st_idle: if (fetch.pending) begin
                state_next = eth_frame_pkg::st_preamble;
                timer_load = 1'b1;
                timer_value = tx_buffer_pkg::addr_t'(`PREAMBLE_BYTES - 1);
            end
            eth_frame_pkg::st_preamble: if (timer_expired) begin
                state_next = eth_frame_pkg::st_sfd;
            end
            eth_frame_pkg::st_sfd: begin
                timer_load = 1'b1;
                if (fetch.frame_len == '0) begin   // empty slot goes straight to fcs
                    state_next = eth_frame_pkg::st_fcs;
                    timer_value = tx_buffer_pkg::addr_t'(FCS_BYTES - 1);
                end else begin
                    state_next = eth_frame_pkg::st_payload;
                    timer_value = fetch.frame_len - 1'b1;
                end
            end
            eth_frame_pkg::st_payload: if (timer_expired) begin
                state_next = eth_frame_pkg::st_fcs;
                timer_load = 1'b1;
                timer_value = tx_buffer_pkg::addr_t'(FCS_BYTES - 1);
            end
            eth_frame_pkg::st_fcs: if (timer_expired) begin
                state_next = eth_frame_pkg::st_gap;
                timer_load = 1'b1;
                timer_value = tx_buffer_pkg::addr_t'(`GAP_CYCLES - 1);
            end
            eth_frame_pkg::st_gap: if (timer_expired) begin
                state_next = eth_frame_pkg::st_idle;
            end
            default: state_next = eth_frame_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= eth_frame_pkg::st_idle;
            byte_addr <= '0;
            fcs_index <= '0;
        end else begin
            state <= state_next;
            if (state == eth_frame_pkg::st_sfd) begin
                byte_addr <= '0;
                fcs_index <= '0;
            end
            if (state == eth_frame_pkg::st_payload) begin
                byte_addr <= byte_addr + 1'b1;
            end
            if (state == eth_frame_pkg::st_fcs) begin
                fcs_index <= fcs_index + 1'b1;
            end
        end
    end

    always_comb begin
        case (state)
            eth_frame_pkg::st_preamble: tx_data = `PREAMBLE_BYTE;
            eth_frame_pkg::st_sfd:      tx_data = `SFD_BYTE;
            eth_frame_pkg::st_payload:  tx_data = fetch.fetch_byte;
            eth_frame_pkg::st_fcs:      tx_data = fcs.crc_value[{fcs_index, 3'b000} +: 8];
            default:                    tx_data = '0;
        endcase
    end

    assign tx_en = state inside {eth_frame_pkg::st_preamble, eth_frame_pkg::st_sfd,
                                 eth_frame_pkg::st_payload, eth_frame_pkg::st_fcs};
    assign fetch.fetch_addr = byte_addr;
    assign fetch.release_slot = state == eth_frame_pkg::st_fcs && timer_expired;   // last fcs byte
    assign fcs.crc_init = state == eth_frame_pkg::st_idle && fetch.pending;
    assign fcs.crc_update = state == eth_frame_pkg::st_payload;
    assign fcs.crc_byte = fetch.fetch_byte;

endmodule

`default_nettype wire

// ==== hw/eth_tx_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_tx_mac (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    start,
    input  tx_buffer_pkg::host_op_t operation,
    input  tx_buffer_pkg::addr_t    address,
    input  eth_frame_pkg::byte_t    value,
    output logic                    done,
    output tx_buffer_pkg::addr_t    result,
    output eth_frame_pkg::byte_t    tx_data,
    output logic                    tx_en
);
    frame_fetch_if        fetch_bus ();
    fcs_if                fcs_bus ();
    logic                 timer_load;
    logic                 timer_expired;
    tx_buffer_pkg::addr_t timer_value;

    packet_ring u_ring (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .operation (operation),
        .address   (address),
        .value     (value),
        .done      (done),
        .result    (result),
        .fetch     (fetch_bus.ring)
    );

    fcs_crc32 u_crc (
        .clock (clock),
        .reset (reset),
        .crc   (fcs_bus.crc)
    );

    frame_timer u_timer (
        .clock      (clock),
        .reset      (reset),
        .load       (timer_load),
        .load_value (timer_value),
        .expired    (timer_expired)
    );

    tx_framer_fsm u_framer (
        .clock         (clock),
        .reset         (reset),
        .fetch         (fetch_bus.framer),
        .fcs           (fcs_bus.framer),
        .timer_load    (timer_load),
        .timer_value   (timer_value),
        .timer_expired (timer_expired),
        .tx_data       (tx_data),
        .tx_en         (tx_en)
    );

endmodule

`default_nettype wire

// ==== tb/eth_tx_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_consts.svh"

module eth_tx_properties (
    input logic                 clock,
    input logic                 reset,
    input logic                 done,
    input eth_frame_pkg::byte_t tx_data,
    input logic                 tx_en
);
    logic [7:0] idle_run;   // low cycles since the last frame

    always_ff @(posedge clock) begin
        if (reset) begin
            idle_run <= 8'(`GAP_CYCLES);
        end else if (tx_en) begin
            idle_run <= '0;
        end else if (idle_run != 8'hff) begin
            idle_run <= idle_run + 1'b1;
        end
    end

    done_single: assert property (@(posedge clock) disable iff (reset) done |=> !done)
        else $error("done stayed high for two cycles");

    preamble_first: assert property (@(posedge clock) disable iff (reset)
        $rose(tx_en) |-> tx_data == `PREAMBLE_BYTE)
        else $error("frame did not open with a preamble byte");

    gap_kept: assert property (@(posedge clock) disable iff (reset)
        $rose(tx_en) |-> idle_run >= 8'(`GAP_CYCLES))
        else $error("inter-frame gap too short");

endmodule

bind eth_tx_mac eth_tx_properties u_properties (
    .clock   (clock),
    .reset   (reset),
    .done    (done),
    .tx_data (tx_data),
    .tx_en   (tx_en)
);

`default_nettype wire

// ==== tb/eth_tx_mac_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_consts.svh"

module eth_tx_mac_tb;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int DRAIN_LIMIT = 1000;

    logic                    clock;
    logic                    reset;
    logic                    start;
    tx_buffer_pkg::host_op_t operation;
    tx_buffer_pkg::addr_t    address;
    eth_frame_pkg::byte_t    value;
    logic                    done;
    tx_buffer_pkg::addr_t    result;
    eth_frame_pkg::byte_t    tx_data;
    logic                    tx_en;

    logic [31:0]          lfsr = 32'h71f2_ef92;
    int                   errors = 0;
    int                   checks = 0;
    int                   limit_cycles = 0;
    bit                   cases_ready = 1'b0;
    int                   rx_run = 0;
    eth_frame_pkg::byte_t payload[$];
    eth_frame_pkg::byte_t rx_bytes[$];
    int                   rx_lens[$];
    eth_frame_pkg::byte_t exp_bytes[$];
    int                   exp_lens[$];
    string                exp_names[$];
    string                case_names[$];
    string                case_kinds[$];
    int                   case_lens[$];
    int                   case_exps[$];

    eth_tx_mac UUT (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .operation (operation),
        .address   (address),
        .value     (value),
        .done      (done),
        .result    (result),
        .tx_data   (tx_data),
        .tx_en     (tx_en)
    );

    always #5 clock = ~clock;

    // frame monitor, one byte per tx_en cycle
    always @(negedge clock) begin
        if (tx_en) begin
            rx_bytes.push_back(tx_data);
            rx_run++;
        end else if (rx_run != 0) begin
            rx_lens.push_back(rx_run);
            rx_run = 0;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? (state >> 1) ^ LFSR_TAPS : state >> 1;
    endfunction

    // reflected crc32, lsb of each byte first
    function automatic logic [31:0] expected_fcs(input eth_frame_pkg::byte_t data[$]);
        logic [31:0] crc;
        crc = `CRC_INIT;
        foreach (data[k]) begin
            for (int i = 0; i < 8; i++) begin
                crc = (crc[0] ^ data[k][i]) ? (crc >> 1) ^ `CRC_POLY : crc >> 1;
            end
        end
        return ~crc;
    endfunction

    function automatic string text_of(input logic [8*24-1:0] packed_text);
        string s;
        s = "";
        for (int i = 23; i >= 0; i--) begin
            if (packed_text[8*i +: 8] != 8'h00) begin
                s = $sformatf("%s%c", s, packed_text[8*i +: 8]);
            end
        end
        return s;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic host_op(input tx_buffer_pkg::host_op_t op, input int addr,
                           input eth_frame_pkg::byte_t data,
                           output tx_buffer_pkg::addr_t res);
        int waited;
        waited = 0;
        @(posedge clock);
        start <= 1'b1;
        operation <= op;
        address <= tx_buffer_pkg::addr_t'(addr);
        value <= data;
        @(posedge clock);
        start <= 1'b0;
        @(negedge clock);
        while (!done && waited < 4) begin
            @(negedge clock);
            waited++;
        end
        if (!done) begin
            errors++;
            $display("no done pulse for operation %0d at address %0d", op, addr);
        end
        res = result;
    endtask

    task automatic make_payload(input int n);
        eth_frame_pkg::byte_t b;
        payload.delete();
        repeat (n) begin
            for (int i = 0; i < 8; i++) begin
                b[i] = lfsr[0];   // one lfsr step per bit
                lfsr = lfsr_step(lfsr);
            end
            payload.push_back(b);
        end
    endtask

    task automatic write_at(input string name, input int addr);
        tx_buffer_pkg::addr_t res;
        host_op(tx_buffer_pkg::op_write, addr, payload[addr], res);
        compare_value($sformatf("%s write %0d", name, addr), 0, 32'(res));
    endtask

    task automatic write_payload(input string name);
        foreach (payload[a]) begin
            write_at(name, a);
        end
    endtask

    task automatic commit_frame(input string name, input int expected);
        tx_buffer_pkg::addr_t res;
        host_op(tx_buffer_pkg::op_write_next, 0, 8'h00, res);
        compare_value({name, " commit"}, expected, 32'(res));
        if (expected == 0) begin
            exp_names.push_back(name);
            exp_lens.push_back(payload.size());
            foreach (payload[k]) begin
                exp_bytes.push_back(payload[k]);
            end
        end
    endtask

    task automatic drain_and_compare();
        int waited;
        int n;
        int got;
        string name;
        logic [31:0] fcs;
        eth_frame_pkg::byte_t data[$];
        eth_frame_pkg::byte_t want;
        waited = 0;
        @(posedge clock);
        while (rx_lens.size() < exp_lens.size() && waited < DRAIN_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        if (rx_lens.size() < exp_lens.size()) begin
            errors++;
            $display("%0d frames never appeared on the line", exp_lens.size() - rx_lens.size());
        end
        while (exp_lens.size() != 0 && rx_lens.size() != 0) begin
            name = exp_names.pop_front();
            n = exp_lens.pop_front();
            got = rx_lens.pop_front();
            data.delete();
            repeat (n) data.push_back(exp_bytes.pop_front());
            fcs = expected_fcs(data);
            compare_value({name, " tx_en cycles"}, 12 + n, got);
            for (int i = 0; i < got; i++) begin
                if (i < n + 12) begin
                    if (i < `PREAMBLE_BYTES)
                        want = `PREAMBLE_BYTE;
                    else if (i == `PREAMBLE_BYTES)
                        want = `SFD_BYTE;
                    else if (i < n + 8)
                        want = data[i - 8];
                    else
                        want = fcs[8 * (i - 8 - n) +: 8];   // fcs low byte first
                    compare_value($sformatf("%s byte %0d", name, i), want, rx_bytes[0]);
                end
                void'(rx_bytes.pop_front());
            end
        end
        exp_names.delete();
        exp_lens.delete();
        exp_bytes.delete();
    endtask

    initial begin
        int fd;
        int fields;
        int n;
        int len_val;
        int exp_val;
        logic [8*80-1:0] line_text;
        logic [8*24-1:0] name_text;
        logic [8*24-1:0] kind_text;
        string name;
        string kind;
        tx_buffer_pkg::addr_t res;
        clock = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        operation = tx_buffer_pkg::op_write;
        address = '0;
        value = '0;
        fd = $fopen("tb/frame_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open tb/frame_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line_text = '0;
                name_text = '0;
                kind_text = '0;
                if ($fgets(line_text, fd) != 0) begin
                    fields = $sscanf(line_text, "%s %s %d %d", name_text, kind_text,
                                     len_val, exp_val);
                    if (fields == 4) begin   // comment lines stop short
                        case_names.push_back(text_of(name_text));
                        case_kinds.push_back(text_of(kind_text));
                        case_lens.push_back(len_val);
                        case_exps.push_back(exp_val);
                        limit_cycles += 4 * len_val + 40;
                    end
                end
            end
            $fclose(fd);
        end
        if (case_names.size() == 0) begin
            errors++;
            $display("no test cases were read");
        end
        limit_cycles += 100 * `SLOT_COUNT + 200;
        cases_ready = 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        foreach (case_names[c]) begin
            name = case_names[c];
            kind = case_kinds[c];
            n = case_lens[c];
            make_payload(n);
            if (kind == "frame") begin
                write_payload(name);
                commit_frame(name, case_exps[c]);
            end else if (kind == "len") begin
                for (int pass = 0; pass < 3; pass++) begin
                    for (int a = n - 1 - pass; a >= 0; a -= 3) begin
                        write_at(name, a);
                    end
                end
                host_op(tx_buffer_pkg::op_write_len, 0, 8'h00, res);
                compare_value({name, " length"}, case_exps[c], 32'(res));
                commit_frame(name, 0);
            end else if (kind == "badaddr") begin
                write_payload(name);
                host_op(tx_buffer_pkg::op_write, `SLOT_BYTES, 8'hee, res);
                compare_value({name, " bad write"}, case_exps[c], 32'(res));
                host_op(tx_buffer_pkg::op_write_len, 0, 8'h00, res);
                compare_value({name, " length"}, n, 32'(res));
                commit_frame(name, 0);
            end else if (kind == "burst") begin
                for (int f = 0; f < `SLOT_COUNT; f++) begin
                    if (f != 0) begin
                        make_payload(2);   // long first frame keeps the ring full
                    end
                    write_payload(name);
                    commit_frame($sformatf("%s frame %0d", name, f), 0);
                end
                payload.delete();
                commit_frame({name, " overflow"}, case_exps[c]);
            end else begin
                errors++;
                $display("unknown kind %s in test %s", kind, name);
            end
            drain_and_compare();
        end
        repeat (40) @(posedge clock);
        compare_value("no extra frames", 0, rx_lens.size());
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (cases_ready);
        repeat (limit_cycles) @(posedge clock);
        $display("timeout after %0d cycles, the run did not complete", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== eth_tx_mac.f ====
+incdir+include
hw/eth_frame_pkg.sv
hw/tx_buffer_pkg.sv
hw/eth_tx_ifs.sv
hw/packet_ring.sv
hw/fcs_crc32.sv
hw/frame_timer.sv
hw/tx_framer_fsm.sv
hw/eth_tx_mac.sv
tb/eth_tx_properties.sv
tb/eth_tx_mac_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module eth_tx_mac_tb -Mdir obj_dir -f eth_tx_mac.f \
    || { echo "build failed"; exit 1; }

./obj_dir/Veth_tx_mac_tb > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL: run did not finish"; exit 1; }

// ==== tb/frame_cases.txt ====
# name              kind     length  expected
# expected is the commit result (frame), length (len), bad write (badaddr), last commit (burst)
one_byte_frame      frame    1       0
empty_frame         frame    0       0
short_frame         frame    6       0
odd_frame           frame    17      0
mid_frame           frame    33      0
full_slot_frame     frame    64      0
len_small           len      5       5
len_mid             len      23      23
len_full_slot       len      64      64
bad_addr_short      badaddr  4       1
bad_addr_empty      badaddr  0       1
bad_addr_full       badaddr  64      1
ring_burst_a        burst    20      1
frame_after_burst   frame    9       0
ring_burst_b        burst    32      1
len_after_burst     len      11      11
